// File: vlog.f
source/nic_cfg_pkg.sv
source/nic_reset_seq.sv
source/ee_frame_rx.sv
source/config_rom.sv
source/ee_data_tx.sv
source/nic_cfg_top.sv
bench/nic_cfg_asserts.sv
bench/tb_nic_cfg.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
# The exit status is the simulation result

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project root"
	exit 1
fi

verilator --binary --assert --timescale 1ns/100ps --top-module tb_nic_cfg -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_nic_cfg
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi
exit 0

// File: bench/tb_nic_cfg.sv
`default_nettype none

module tb_nic_cfg;
	timeunit 1ns;
	timeprecision 100ps;
	import nic_cfg_pkg::*;

	localparam mac_addr_t MAC_ADDR   = 48'h00_1B_21_3C_5D_7E;
	localparam int        RST_CNT_W  = 7;
	localparam int        REL_CYC    = 2 ** (RST_CNT_W - 1);
	localparam int        CLK_PERIOD = 4;
	// One host sk period, two 8-cycle phases
	localparam int        BIT_CYC    = 16;
	// Select, header, one word, deselect
	localparam int        FRAME_CYC  = (EE_ADDR_W + 3 + EE_WORD_W + 2) * BIT_CYC;
	// Three release waits, 16 frames, extra streamed words of two long reads
	localparam int        RUN_CYC    = 3 * (REL_CYC + 40) + 16 * FRAME_CYC
	                                   + (3 + EE_TABLE_WORDS - 1) * EE_WORD_W * BIT_CYC;
	localparam int        WATCHDOG_CYC = RUN_CYC + 2000;

	logic        nic_clk;
	logic        ext_rst;
	logic        clk_locked;
	logic        reset_request;
	logic        eecs;
	logic        eesk;
	logic        eedi;
	logic        nic_rst;
	logic        eedo;
	logic        eedo_oe;
	logic [31:0] rng_state;
	// Captured words and their addresses, drained by the compare process
	ee_addr_t    rd_addr_q[$];
	ee_word_t    rd_word_q[$];
	// Running sum of words read back from the DUT
	ee_word_t    rd_sum;

	nic_cfg_top #(
		.MAC_ADDR (MAC_ADDR),
		.RST_CNT_W(RST_CNT_W)
	) i_dut (
		.nic_clk        (nic_clk),
		.ext_rst        (ext_rst),
		.clk_locked_i   (clk_locked),
		.reset_request_i(reset_request),
		.eecs_i         (eecs),
		.eesk_i         (eesk),
		.eedi_i         (eedi),
		.nic_rst_o      (nic_rst),
		.eedo_o         (eedo),
		.eedo_oe_o      (eedo_oe)
	);

	initial nic_clk = 1'b0;
	always #(CLK_PERIOD / 2) nic_clk = ~nic_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Octet k of the MAC, octet 0 first on the wire
	function automatic logic [7:0] mac_octet(input int k);
		mac_addr_t sh;
		sh = MAC_ADDR >> (8 * (5 - k));
		return sh[7:0];
	endfunction

	// Image below the checksum word, even octet in the low half
	function automatic ee_word_t image_word(input ee_addr_t a);
		if (a < 8'h03) begin
			return {mac_octet(2 * int'(a) + 1), mac_octet(2 * int'(a))};
		end
		return EE_DEFAULT_WORDS[a[5:0]];
	endfunction

	function automatic ee_word_t ref_word(input ee_addr_t a);
		ee_word_t sum;
		if (a > EE_CSUM_ADDR) begin
			return 16'hFFFF;
		end
		if (a != EE_CSUM_ADDR) begin
			return image_word(a);
		end
		sum = '0;
		for (int i = 0; i < EE_TABLE_WORDS - 1; i++) begin
			sum = sum + image_word(ee_addr_t'(i));
		end
		return EE_CSUM_TARGET - sum;
	endfunction

	task automatic check_word(input string name, input ee_word_t exp, input ee_word_t got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			$display("Regression failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, got);
			$display("Regression failed");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		if (got != exp) begin
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
			$display("Regression failed");
			$fatal(1, "count mismatch");
		end
	endtask

	// One sk period, data out sampled late in the high phase
	task automatic sk_bit(input logic di, output logic do_bit, output logic oe_bit);
		eedi = di;
		eesk = 1'b0;
		repeat (8) @(negedge nic_clk);
		eesk = 1'b1;
		repeat (8) @(negedge nic_clk);
		do_bit = eedo;
		oe_bit = eedo_oe;
	endtask

	task automatic cs_select();
		eecs = 1'b1;
		eesk = 1'b0;
		repeat (4) @(negedge nic_clk);
	endtask

	task automatic cs_release();
		eecs = 1'b0;
		eesk = 1'b0;
		eedi = 1'b0;
		repeat (8) @(negedge nic_clk);
		check_bit("eedo_oe_o", 1'b0, eedo_oe);
	endtask

	// Leading zeros, start bit, opcode, address; returns the dummy slot
	task automatic send_header(input ee_opcode_t op, input ee_addr_t addr, input int lead,
	                           output logic do_bit, output logic oe_bit);
		logic [EE_ADDR_W+2:0] hdr;
		logic                 d;
		logic                 o;
		hdr = {1'b1, op, addr};
		for (int i = 0; i < lead; i++) begin
			sk_bit(1'b0, d, o);
		end
		for (int i = 0; i < EE_ADDR_W + 3; i++) begin
			sk_bit(hdr[EE_ADDR_W+2], do_bit, oe_bit);
			hdr = {hdr[EE_ADDR_W+1:0], 1'b0};
		end
	endtask

	task automatic shift_word(output ee_word_t w);
		logic d;
		logic o;
		w = '0;
		for (int i = 0; i < EE_WORD_W; i++) begin
			sk_bit(1'b0, d, o);
			check_bit("eedo_oe_o", 1'b1, o);
			w = {w[EE_WORD_W-2:0], d};
		end
	endtask

	task automatic read_frame(input ee_addr_t start, input int words, input int lead);
		logic     d;
		logic     o;
		ee_word_t w;
		cs_select();
		send_header(READ, start, lead, d, o);
		check_bit("dummy eedo_o", 1'b0, d);
		check_bit("eedo_oe_o", 1'b1, o);
		for (int i = 0; i < words; i++) begin
			shift_word(w);
			rd_addr_q.push_back(ee_addr_t'(start + i));
			rd_word_q.push_back(w);
			rd_sum = rd_sum + w;
		end
		cs_release();
	endtask

	// Non-READ opcode, line must stay released
	task automatic ignored_frame(input ee_opcode_t op, input ee_addr_t addr);
		logic d;
		logic o;
		cs_select();
		send_header(op, addr, 0, d, o);
		check_bit("eedo_oe_o", 1'b0, o);
		for (int i = 0; i < EE_WORD_W; i++) begin
			sk_bit(1'b0, d, o);
			check_bit("eedo_oe_o", 1'b0, o);
		end
		cs_release();
	endtask

	// Deselect mid-word, enable drops after the 3-cycle sync path
	task automatic aborted_frame(input ee_addr_t addr);
		logic d;
		logic o;
		cs_select();
		send_header(READ, addr, 1, d, o);
		for (int i = 0; i < 7; i++) begin
			sk_bit(1'b0, d, o);
		end
		check_bit("eedo_oe_o", 1'b1, o);
		eecs = 1'b0;
		eesk = 1'b0;
		repeat (2) @(negedge nic_clk);
		check_bit("eedo_oe_o", 1'b1, eedo_oe);
		@(negedge nic_clk);
		check_bit("eedo_oe_o", 1'b0, eedo_oe);
		repeat (8) @(negedge nic_clk);
	endtask

	// Cycles until nic_rst_o falls, output enable low all along
	task automatic wait_release(output int cycles);
		cycles = 0;
		do begin
			@(negedge nic_clk);
			cycles++;
			check_bit("eedo_oe_o", 1'b0, eedo_oe);
		end while (nic_rst && cycles < 4 * REL_CYC);
	endtask

	// Compare process, every captured word against the reference
	initial begin : compare_proc
		ee_addr_t a;
		forever begin
			@(posedge nic_clk);
			while (rd_word_q.size() > 0) begin
				a = rd_addr_q.pop_front();
				check_word($sformatf("word[%02h]", a), ref_word(a), rd_word_q.pop_front());
			end
		end
	end

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Simulation timed out after %0d cycles", WATCHDOG_CYC);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int       cycles;
		ee_addr_t ra;
		ext_rst       = 1'b1;
		clk_locked    = 1'b1;
		reset_request = 1'b0;
		eecs          = 1'b0;
		eesk          = 1'b0;
		eedi          = 1'b0;
		rng_state     = 32'h7a2d_3ef3;
		rd_sum        = '0;
		repeat (8) @(negedge nic_clk);
		check_bit("nic_rst_o", 1'b1, nic_rst);
		ext_rst = 1'b0;
		wait_release(cycles);
		check_count("release after ext_rst", REL_CYC, cycles);

		// Software request pulse
		reset_request = 1'b1;
		@(negedge nic_clk);
		check_bit("nic_rst_o", 1'b1, nic_rst);
		reset_request = 1'b0;
		wait_release(cycles);
		check_count("release after reset_request_i", REL_CYC, cycles);

		// Lock lost for a while
		clk_locked = 1'b0;
		repeat (10) @(negedge nic_clk);
		check_bit("nic_rst_o", 1'b1, nic_rst);
		clk_locked = 1'b1;
		wait_release(cycles);
		check_count("release after clk_locked_i", REL_CYC, cycles);

		read_frame(8'h00, 1, 0);
		read_frame(8'h01, 1, 2);
		read_frame(8'h02, 1, 0);
		read_frame(EE_CSUM_ADDR, 1, 1);

		// Whole image streamed from the DUT must sum to the target
		rd_sum = '0;
		read_frame(8'h00, EE_TABLE_WORDS, 0);
		check_word("checksum total", EE_CSUM_TARGET, rd_sum);

		// Half the random reads inside the defined table
		for (int i = 0; i < 4; i++) begin
			rng_state = xorshift32(rng_state);
			ra = (i % 2 == 0) ? ee_addr_t'(rng_state[5:0]) : rng_state[7:0];
			read_frame(ra, 1, 0);
		end

		// Streamed read across the FF to 00 wrap
		rng_state = xorshift32(rng_state);
		read_frame(ee_addr_t'(8'hFD + rng_state % 3), 4, 0);

		rng_state = xorshift32(rng_state);
		ignored_frame(WRITE, rng_state[7:0]);
		ignored_frame(ERASE, rng_state[15:8]);
		ignored_frame(MISC, rng_state[23:16]);
		read_frame(ee_addr_t'(rng_state[29:24]), 1, 0);

		rng_state = xorshift32(rng_state);
		aborted_frame(ee_addr_t'(rng_state[5:0]));
		read_frame(rng_state[15:8], 1, 0);

		repeat (4) @(negedge nic_clk);
		if (rd_word_q.size() != 0) begin
			$display("Captured words were left unchecked");
			$display("Regression failed");
			$fatal(1, "compare queue not drained");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: bench/nic_cfg_asserts.sv
`default_nettype none

module nic_cfg_asserts #(
	parameter int RST_CNT_W = 7
) (
	input logic nic_clk,
	input logic ext_rst,
	input logic clk_locked_i,
	input logic reset_request_i,
	input logic eecs_i,
	input logic nic_rst_i,
	input logic eedo_i,
	input logic eedo_oe_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// Minimum reset hold after a clear condition
	localparam logic [RST_CNT_W:0] HOLD_CYC = {2'b01, {(RST_CNT_W - 1){1'b0}}};

	// Cycles since the last clear condition, saturating
	logic [RST_CNT_W:0] since_clr_q;
	logic               clr_req;

	assign clr_req = !clk_locked_i || reset_request_i;

	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			since_clr_q <= '0;
		end else if (clr_req) begin
			since_clr_q <= '0;
		end else if (!since_clr_q[RST_CNT_W]) begin
			since_clr_q <= since_clr_q + 1'b1;
		end
	end

	// Output enable only while selected
	// Synchronized cs lags the pin by three cycles
	oe_needs_cs: assert property (@(posedge nic_clk) disable iff (ext_rst)
		eedo_oe_i |-> $past(eecs_i, 3))
		else $error("eedo_oe_o high while synchronized cs is low");

	// Dummy zero in the first enabled cycle
	dummy_low: assert property (@(posedge nic_clk) disable iff (ext_rst)
		$rose(eedo_oe_i) |-> !eedo_i)
		else $error("eedo_o not low in the first cycle of eedo_oe_o");

	// Reset held through the whole release window
	rst_hold: assert property (@(posedge nic_clk) disable iff (ext_rst)
		(since_clr_q < HOLD_CYC) |-> nic_rst_i)
		else $error("nic_rst_o released too early after a clear condition");

endmodule

bind nic_cfg_top nic_cfg_asserts #(
	.RST_CNT_W(RST_CNT_W)
) i_asserts (
	.nic_clk        (nic_clk),
	.ext_rst        (ext_rst),
	.clk_locked_i   (clk_locked_i),
	.reset_request_i(reset_request_i),
	.eecs_i         (eecs_i),
	.nic_rst_i      (nic_rst_o),
	.eedo_i         (eedo_o),
	.eedo_oe_i      (eedo_oe_o)
);

`default_nettype wire

// File: source/nic_cfg_top.sv
`default_nettype none

module nic_cfg_top #(
	parameter nic_cfg_pkg::mac_addr_t MAC_ADDR  = 48'h02_4E_49_43_00_01,
	parameter int                     RST_CNT_W = 7
) (
	input  logic nic_clk,
	input  logic ext_rst,
	input  logic clk_locked_i,
	input  logic reset_request_i,
	input  logic eecs_i,
	input  logic eesk_i,
	input  logic eedi_i,
	output logic nic_rst_o,
	output logic eedo_o,
	output logic eedo_oe_o
);
	import nic_cfg_pkg::*;

	// EEPROM stages follow the NIC domain reset
	logic        ee_rst;
	ee_pin_evt_t ee_evt;
	ee_cmd_t     ee_cmd;
	logic        ee_cmd_stb;
	ee_word_t    ee_word;
	logic        ee_word_stb;
	logic        ee_next_stb;

	assign ee_rst = ext_rst || nic_rst_o;

	// NIC domain reset release
	nic_reset_seq #(
		.RST_CNT_W(RST_CNT_W)
	) i_rst_seq (
		.nic_clk        (nic_clk),
		.ext_rst        (ext_rst),
		.clk_locked_i   (clk_locked_i),
		.reset_request_i(reset_request_i),
		.nic_rst_o      (nic_rst_o)
	);

	// Pin sync and command header decode
	ee_frame_rx i_frame_rx (
		.nic_clk  (nic_clk),
		.ext_rst  (ee_rst),
		.eecs_i   (eecs_i),
		.eesk_i   (eesk_i),
		.eedi_i   (eedi_i),
		.evt_o    (ee_evt),
		.cmd_o    (ee_cmd),
		.cmd_stb_o(ee_cmd_stb)
	);

	// Word lookup with MAC and checksum
	config_rom #(
		.MAC_ADDR(MAC_ADDR)
	) i_rom (
		.nic_clk   (nic_clk),
		.ext_rst   (ee_rst),
		.cmd_i     (ee_cmd),
		.cmd_stb_i (ee_cmd_stb),
		.next_stb_i(ee_next_stb),
		.word_o    (ee_word),
		.word_stb_o(ee_word_stb)
	);

	// Serial data out and output enable
	ee_data_tx i_data_tx (
		.nic_clk   (nic_clk),
		.ext_rst   (ee_rst),
		.evt_i     (ee_evt),
		.cmd_stb_i (ee_cmd_stb),
		.cmd_i     (ee_cmd),
		.word_i    (ee_word),
		.word_stb_i(ee_word_stb),
		.next_stb_o(ee_next_stb),
		.eedo_o    (eedo_o),
		.eedo_oe_o (eedo_oe_o)
	);

endmodule

`default_nettype wire

// File: source/ee_data_tx.sv
`default_nettype none

module ee_data_tx (
	input  logic                     nic_clk,
	input  logic                     ext_rst,
	input  nic_cfg_pkg::ee_pin_evt_t evt_i,
	input  logic                     cmd_stb_i,
	input  nic_cfg_pkg::ee_cmd_t     cmd_i,
	input  nic_cfg_pkg::ee_word_t    word_i,
	input  logic                     word_stb_i,
	output logic                     next_stb_o,
	output logic                     eedo_o,
	output logic                     eedo_oe_o
);
	import nic_cfg_pkg::*;

	localparam int BIT_CNT_W = $clog2(EE_WORD_W);

	logic                 oe_q;
	logic                 do_q;
	// Next word, filled while the current one shifts out
	ee_word_t             buf_q;
	// Bits of the current word not yet presented
	logic [EE_WORD_W-2:0] shift_q;
	// Bit position in the current word, 0 means take a new word
	logic [BIT_CNT_W-1:0] bit_pos_q;
	logic                 next_stb_q;
	logic                 rd_start;
	logic                 bit_adv;

	assign rd_start = cmd_stb_i && (cmd_i.opcode == READ);
	// Each sk rise while selected presents one bit
	assign bit_adv  = oe_q && evt_i.cs && evt_i.sk_rise;

	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			oe_q       <= 1'b0;
			do_q       <= 1'b0;
			bit_pos_q  <= '0;
			next_stb_q <= 1'b0;
		end else begin
			next_stb_q <= 1'b0;
			if (!evt_i.cs) begin
				// Deselect releases the line at once
				oe_q      <= 1'b0;
				do_q      <= 1'b0;
				bit_pos_q <= '0;
			end else if (rd_start) begin
				// Dummy zero ahead of the first data bit
				oe_q      <= 1'b1;
				do_q      <= 1'b0;
				bit_pos_q <= '0;
			end else if (bit_adv) begin
				if (bit_pos_q == '0) begin
					do_q <= buf_q[EE_WORD_W-1];
				end else begin
					do_q <= shift_q[EE_WORD_W-2];
				end
				bit_pos_q  <= bit_pos_q + 1'b1;
				// Bit 0 going out, fetch the following address
				next_stb_q <= (bit_pos_q == '1);
			end
		end
	end

	always_ff @(posedge nic_clk) begin
		if (word_stb_i) begin
			buf_q <= word_i;
		end
		if (bit_adv) begin
			if (bit_pos_q == '0) begin
				shift_q <= buf_q[EE_WORD_W-2:0];
			end else begin
				shift_q <= {shift_q[EE_WORD_W-3:0], 1'b0};
			end
		end
	end

	assign next_stb_o = next_stb_q;
	assign eedo_o     = do_q;
	// Enable drops in the same cycle as synchronized cs
	assign eedo_oe_o  = oe_q && evt_i.cs;

endmodule

`default_nettype wire

// File: source/config_rom.sv
`default_nettype none

module config_rom #(
	parameter nic_cfg_pkg::mac_addr_t MAC_ADDR = 48'h02_4E_49_43_00_01
) (
	input  logic                  nic_clk,
	input  logic                  ext_rst,
	input  nic_cfg_pkg::ee_cmd_t  cmd_i,
	input  logic                  cmd_stb_i,
	input  logic                  next_stb_i,
	output nic_cfg_pkg::ee_word_t word_o,
	output logic                  word_stb_o
);
	import nic_cfg_pkg::*;

	localparam int TBL_AW = $clog2(EE_TABLE_WORDS);

	// Octet 2n in the low half of word n
	localparam ee_word_t MAC_WORD0 = {MAC_ADDR[39:32], MAC_ADDR[47:40]};
	localparam ee_word_t MAC_WORD1 = {MAC_ADDR[23:16], MAC_ADDR[31:24]};
	localparam ee_word_t MAC_WORD2 = {MAC_ADDR[7:0], MAC_ADDR[15:8]};

	// Sum of words 0 to 3E, checksum makes the total hit the target
	function automatic ee_word_t calc_csum();
		ee_word_t sum;
		sum = MAC_WORD0 + MAC_WORD1 + MAC_WORD2;
		for (int i = 3; i < EE_TABLE_WORDS - 1; i++) begin
			sum = sum + EE_DEFAULT_WORDS[i];
		end
		return EE_CSUM_TARGET - sum;
	endfunction

	localparam ee_word_t CSUM_WORD = calc_csum();

	function automatic ee_word_t rom_word(input ee_addr_t addr);
		ee_word_t w;
		if (addr > EE_CSUM_ADDR) begin
			// Unpopulated area reads as erased
			w = 16'hFFFF;
		end else if (addr == EE_CSUM_ADDR) begin
			w = CSUM_WORD;
		end else begin
			case (addr)
				8'h00:   w = MAC_WORD0;
				8'h01:   w = MAC_WORD1;
				8'h02:   w = MAC_WORD2;
				default: w = EE_DEFAULT_WORDS[addr[TBL_AW-1:0]];
			endcase
		end
		return w;
	endfunction

	// Current read address
	ee_addr_t rd_addr_q;
	ee_addr_t rd_addr;
	ee_word_t word_q;
	logic     word_stb_q;
	logic     rd_load;
	logic     rd_fetch;

	// New READ takes priority over a sequential request
	assign rd_load  = cmd_stb_i && (cmd_i.opcode == READ);
	assign rd_fetch = rd_load || next_stb_i;
	// Increment wraps from FF to 00
	assign rd_addr  = rd_load ? cmd_i.addr : rd_addr_q + 1'b1;

	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rd_addr_q  <= '0;
			word_stb_q <= 1'b0;
		end else begin
			word_stb_q <= rd_fetch;
			if (rd_fetch) begin
				rd_addr_q <= rd_addr;
			end
		end
	end

	always_ff @(posedge nic_clk) begin
		if (rd_fetch) begin
			word_q <= rom_word(rd_addr);
		end
	end

	assign word_o     = word_q;
	assign word_stb_o = word_stb_q;

endmodule

`default_nettype wire

// File: source/ee_frame_rx.sv
`default_nettype none

module ee_frame_rx (
	input  logic                     nic_clk,
	input  logic                     ext_rst,
	input  logic                     eecs_i,
	input  logic                     eesk_i,
	input  logic                     eedi_i,
	output nic_cfg_pkg::ee_pin_evt_t evt_o,
	output nic_cfg_pkg::ee_cmd_t     cmd_o,
	output logic                     cmd_stb_o
);
	import nic_cfg_pkg::*;

	// Opcode plus address bits after the start bit
	localparam int FRAME_BITS = $bits(ee_cmd_t);
	localparam int CNT_W      = $clog2(FRAME_BITS + 1);

	// Pin order in the synchronizer is {cs, sk, di}
	logic [2:0]            pin_s1_q;
	logic [2:0]            pin_s2_q;
	// Previous synchronized sk for edge detect
	logic                  sk_last_q;
	ee_pin_evt_t           evt_q;
	// Header shift register, newest bit at LSB
	logic [FRAME_BITS-1:0] frame_q;
	logic [CNT_W-1:0]      bit_cnt_q;
	// Start bit seen
	logic                  started_q;
	// Header complete, rest of frame ignored
	logic                  done_q;
	logic                  cmd_stb_q;
	logic                  shift_en;

	// Pins are asynchronous to nic_clk
	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			pin_s1_q  <= '0;
			pin_s2_q  <= '0;
			sk_last_q <= 1'b0;
			evt_q     <= '0;
		end else begin
			pin_s1_q      <= {eecs_i, eesk_i, eedi_i};
			pin_s2_q      <= pin_s1_q;
			sk_last_q     <= pin_s2_q[1];
			// Event word registered so cs, di and the edge stay aligned
			evt_q.sk_rise <= pin_s2_q[1] && !sk_last_q;
			evt_q.di      <= pin_s2_q[0];
			evt_q.cs      <= pin_s2_q[2];
		end
	end

	// Header bits only after the start bit and before completion
	assign shift_en = evt_q.cs && evt_q.sk_rise && started_q && !done_q;

	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			bit_cnt_q <= '0;
			started_q <= 1'b0;
			done_q    <= 1'b0;
			cmd_stb_q <= 1'b0;
		end else begin
			cmd_stb_q <= 1'b0;
			if (!evt_q.cs) begin
				// Deselect restarts the frame
				bit_cnt_q <= '0;
				started_q <= 1'b0;
				done_q    <= 1'b0;
			end else if (evt_q.sk_rise && !started_q) begin
				// Leading zeros skipped until a one arrives
				started_q <= evt_q.di;
			end else if (shift_en) begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (bit_cnt_q == CNT_W'(FRAME_BITS - 1)) begin
					done_q    <= 1'b1;
					cmd_stb_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge nic_clk) begin
		if (shift_en) begin
			frame_q <= {frame_q[FRAME_BITS-2:0], evt_q.di};
		end
	end

	// Header frozen after completion until cs drops
	assign cmd_o     = ee_cmd_t'(frame_q);
	assign cmd_stb_o = cmd_stb_q;
	assign evt_o     = evt_q;

endmodule

`default_nettype wire

// File: source/nic_reset_seq.sv
`default_nettype none

module nic_reset_seq #(
	parameter int RST_CNT_W = 7
) (
	input  logic nic_clk,
	input  logic ext_rst,
	input  logic clk_locked_i,
	input  logic reset_request_i,
	output logic nic_rst_o
);

	// Release counter, top bit set once enough clean cycles passed
	logic [RST_CNT_W-1:0] rel_cnt_q;
	// Restart condition from clock generator or software
	logic                 clr_req;

	// Lost lock or software reset both restart the count
	assign clr_req = !clk_locked_i || reset_request_i;

	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rel_cnt_q <= '0;
		end else if (clr_req) begin
			rel_cnt_q <= '0;
		end else if (!rel_cnt_q[RST_CNT_W-1]) begin
			// Count up until top bit, then hold
			rel_cnt_q <= rel_cnt_q + 1'b1;
		end
	end

	// Reset held while top bit still clear
	assign nic_rst_o = !rel_cnt_q[RST_CNT_W-1];

endmodule

`default_nettype wire

// File: source/nic_cfg_pkg.sv
`default_nettype none

package nic_cfg_pkg;

	// EEPROM geometry, 256 words of 16 bits
	localparam int EE_ADDR_W = 8;
	localparam int EE_WORD_W = 16;

	typedef logic [EE_ADDR_W-1:0] ee_addr_t;
	typedef logic [EE_WORD_W-1:0] ee_word_t;

	// Station MAC, octet 0 (first on the wire) in bits 47:40
	typedef logic [47:0] mac_addr_t;

	// Microwire opcodes, only READ is answered
	typedef enum logic [1:0] {
		MISC  = 2'b00,
		WRITE = 2'b01,
		READ  = 2'b10,
		ERASE = 2'b11
	} ee_opcode_t;

	// Command header following the start bit, MSB first on the pins
	typedef struct packed {
		ee_opcode_t opcode;
		ee_addr_t   addr;
	} ee_cmd_t;

	// Synchronized pin view handed from the input side to the output side
	typedef struct packed {
		logic sk_rise;
		logic di;
		logic cs;
	} ee_pin_evt_t;

	// Words 0 to 3F carry content, the checksum word closes the table
	localparam int       EE_TABLE_WORDS = 64;
	localparam ee_addr_t EE_CSUM_ADDR   = 8'h3F;
	localparam ee_word_t EE_CSUM_TARGET = 16'hBABA;

	// Defaults for words 3 to 3E
	// Words 0 to 2 come from the MAC and 3F from the checksum logic
	localparam ee_word_t EE_DEFAULT_WORDS [EE_TABLE_WORDS] = '{
		16'h0000, 16'h0000, 16'h0000, 16'h0A20, 16'hF746, 16'h2010, 16'hFFFF, 16'hFFFF,
		16'h0000, 16'h0000, 16'h6C0B, 16'h0001, 16'h5A17, 16'h10E2, 16'h7C31, 16'h3040,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0100, 16'h4000, 16'h121C, 16'h4007, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF,
		16'h0602, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000
	};

endpackage

`default_nettype wire
